/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

    // ------------------------------------------------------------
    // L2 refill side
    // ------------------------------------------------------------

    // 40-bit physical address less the 6 line offset bits
    localparam int BLOCK_ADDR_W = 34;

    localparam int BEAT_W     = 128;              // One grant beat
    localparam int BEATS      = 4;                // Beats per line
    localparam int BEAT_IDX_W = 2;
    localparam int LINE_W     = BEATS * BEAT_W;   // Assembled line, 512 bits

    localparam logic [BEAT_IDX_W-1:0] LAST_BEAT = 2'd3;

    // ------------------------------------------------------------
    // Data cache port
    // ------------------------------------------------------------

    localparam int PADDR_W   = 40;
    localparam int DWORD_W   = 64;
    localparam int PTW_CMD_W = 5;
    localparam int DC_SIZE_W = 3;
    localparam int DC_BE_W   = 8;

    // Walker command used to set the A and D bits of a PTE
    localparam logic [PTW_CMD_W-1:0] PTW_CMD_AMO_OR = 5'b01010;

    localparam logic [DC_BE_W-1:0] BE_FULL = 8'hff;
    localparam logic [DC_BE_W-1:0] BE_NONE = 8'h00;

    // Operation presented to the data cache
    typedef enum logic {
        DC_OP_LOAD   = 1'b0,
        DC_OP_AMO_OR = 1'b1
    } dc_op_e;

endpackage

/* src/hpm_pkg.sv */
package hpm_pkg;

    // ------------------------------------------------------------
    // Counter geometry
    // ------------------------------------------------------------

    localparam int HPM_COUNTERS = 4;
    localparam int HPM_ADDR_W   = 12;
    localparam int HPM_CNT_W    = 64;

    // Counter k lives at HPM_BASE_ADDR + k
    localparam logic [HPM_ADDR_W-1:0] HPM_BASE_ADDR = 12'hB03;

    // ------------------------------------------------------------
    // Event bit positions
    // ------------------------------------------------------------

    localparam int EV_REFILL   = 0;   // Refill completed
    localparam int EV_L2_HIT   = 1;   // Completed refill that hit in L2
    localparam int EV_PTW_LOAD = 2;   // Walker load taken by the cache
    localparam int EV_PTW_AMO  = 3;   // Walker AMO taken by the cache

endpackage

/* src/refill_bridge.sv */
`timescale 1ns/1ps

module refill_bridge
    import mem_bus_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RST,

    // Fill request from the instruction cache
    input  logic                    fill_req_i,
    input  logic [BLOCK_ADDR_W-1:0] fill_addr_i,

    // Grant beats from the L2
    input  logic                    grant_valid_i,
    input  logic [BEAT_IDX_W-1:0]   grant_beat_i,
    input  logic [BEAT_W-1:0]       grant_data_i,
    input  logic                    l2_hit_i,         // Valid with the last beat

    // Acquire toward the L2
    output logic                    acquire_valid_o,
    output logic [BLOCK_ADDR_W-1:0] acquire_addr_o,

    // Completed line
    output logic                    fill_done_o,
    output logic [LINE_W-1:0]       fill_line_o,

    // Performance events
    output logic                    ev_refill_o,
    output logic                    ev_l2_hit_o
);

    logic                         busy_q;
    logic                         acquire_valid_q;
    logic [BLOCK_ADDR_W-1:0]      acquire_addr_q;
    logic                         done_q;
    logic                         l2_hit_q;
    logic [BEATS-1:0][BEAT_W-1:0] line_q;             // Beat 0 in the low bits

    logic fill_start;
    logic grant_fire;
    logic grant_last;

    assign fill_start = fill_req_i & ~busy_q;          // Only one acquire outstanding
    assign grant_fire = grant_valid_i & busy_q;
    assign grant_last = grant_fire & (grant_beat_i == LAST_BEAT);

    // ------------------------------------------------------------
    // Refill control
    // ------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            busy_q          <= 1'b0;
            acquire_valid_q <= 1'b0;
            done_q          <= 1'b0;
            l2_hit_q        <= 1'b0;
        end else begin
            acquire_valid_q <= fill_start;             // Single cycle pulse
            done_q          <= grant_last;
            l2_hit_q        <= grant_last & l2_hit_i;
            if (fill_start) begin
                busy_q <= 1'b1;
            end else if (grant_last) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Address and line buffer
    always_ff @(posedge CLK) begin
        if (fill_start) begin
            acquire_addr_q <= fill_addr_i;
        end
        if (grant_fire) begin
            line_q[grant_beat_i] <= grant_data_i;      // Beats may arrive in any order
        end
    end

    assign acquire_valid_o = acquire_valid_q;
    assign acquire_addr_o  = acquire_addr_q;
    assign fill_done_o     = done_q;
    assign fill_line_o     = line_q;
    assign ev_refill_o     = done_q;
    assign ev_l2_hit_o     = l2_hit_q;

endmodule

/* src/ptw_dcache_port.sv */
`timescale 1ns/1ps

module ptw_dcache_port
    import mem_bus_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RST,

    // Walker request
    input  logic                 ptw_valid_i,
    input  logic [PADDR_W-1:0]   ptw_addr_i,
    input  logic [DWORD_W-1:0]   ptw_data_i,
    input  logic [PTW_CMD_W-1:0] ptw_cmd_i,
    input  logic [DC_SIZE_W-1:0] ptw_size_i,
    output logic                 ptw_ready_o,

    // Data cache request
    input  logic                 dc_ready_i,
    output logic                 dc_valid_o,
    output logic [PADDR_W-1:0]   dc_addr_o,
    output logic [DWORD_W-1:0]   dc_wdata_o,
    output dc_op_e               dc_op_o,
    output logic [DC_BE_W-1:0]   dc_be_o,
    output logic [DC_SIZE_W-1:0] dc_size_o,

    output logic [PADDR_W-1:0]   last_addr_o,   // Last address taken by the cache

    output logic                 ev_load_o,
    output logic                 ev_amo_o
);

    logic                 valid_q;
    logic [PADDR_W-1:0]   addr_q;
    logic [DWORD_W-1:0]   wdata_q;
    dc_op_e               op_q;
    logic [DC_BE_W-1:0]   be_q;
    logic [DC_SIZE_W-1:0] size_q;
    logic [PADDR_W-1:0]   last_addr_q;

    dc_op_e             req_op;
    logic [DC_BE_W-1:0] req_be;
    logic               ptw_fire;
    logic               dc_fire;

    // Command decode, AMO_OR writes the whole dword
    always_comb begin
        if (ptw_cmd_i == PTW_CMD_AMO_OR) begin
            req_op = DC_OP_AMO_OR;
            req_be = BE_FULL;
        end else begin
            req_op = DC_OP_LOAD;
            req_be = BE_NONE;
        end
    end

    assign ptw_ready_o = ~valid_q | dc_ready_i;    // Slot empty or draining
    assign ptw_fire    = ptw_valid_i & ptw_ready_o;
    assign dc_fire     = valid_q & dc_ready_i;

    // ------------------------------------------------------------
    // Output register and last address
    // ------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            valid_q     <= 1'b0;
            last_addr_q <= '0;
        end else begin
            if (ptw_fire) begin
                valid_q <= 1'b1;
            end else if (dc_fire) begin
                valid_q <= 1'b0;
            end
            if (dc_fire) begin
                last_addr_q <= addr_q;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (ptw_fire) begin
            addr_q  <= ptw_addr_i;
            wdata_q <= ptw_data_i;
            op_q    <= req_op;
            be_q    <= req_be;
            size_q  <= ptw_size_i;
        end
    end

    assign dc_valid_o  = valid_q;
    assign dc_addr_o   = addr_q;
    assign dc_wdata_o  = wdata_q;
    assign dc_op_o     = op_q;
    assign dc_be_o     = be_q;
    assign dc_size_o   = size_q;
    assign last_addr_o = last_addr_q;

    // One pulse per transfer into the cache
    assign ev_load_o = dc_fire & (op_q == DC_OP_LOAD);
    assign ev_amo_o  = dc_fire & (op_q == DC_OP_AMO_OR);

endmodule

/* src/hpm_counters.sv */
`timescale 1ns/1ps

module hpm_counters
    import hpm_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RST,

    input  logic [HPM_COUNTERS-1:0] events_i,     // One bit per counter

    // CSR style access port
    input  logic [HPM_ADDR_W-1:0]   addr_i,
    input  logic                    we_i,
    input  logic [HPM_CNT_W-1:0]    wdata_i,
    output logic [HPM_CNT_W-1:0]    rdata_o
);

    logic [HPM_CNT_W-1:0]    cnt_q [HPM_COUNTERS];
    logic [HPM_COUNTERS-1:0] sel;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------

    // One-hot select, unmapped addresses leave it all zero
    always_comb begin
        for (int k = 0; k < HPM_COUNTERS; k++) begin
            sel[k] = (addr_i == HPM_ADDR_W'(HPM_BASE_ADDR + k));
        end
    end

    // ------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            for (int k = 0; k < HPM_COUNTERS; k++) begin
                cnt_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < HPM_COUNTERS; k++) begin
                if (we_i && sel[k]) begin
                    cnt_q[k] <= wdata_i;             // Write beats a same cycle event
                end else if (events_i[k]) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                end
            end
        end
    end

    // Combinational read
    always_comb begin
        rdata_o = '0;
        for (int k = 0; k < HPM_COUNTERS; k++) begin
            if (sel[k]) begin
                rdata_o = cnt_q[k];
            end
        end
    end

endmodule

/* src/mem_glue_top.sv */
`timescale 1ns/1ps

module mem_glue_top
    import mem_bus_pkg::*, hpm_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RST,

    // L2 refill side
    input  logic                    fill_req_i,
    input  logic [BLOCK_ADDR_W-1:0] fill_addr_i,
    input  logic                    grant_valid_i,
    input  logic [BEAT_IDX_W-1:0]   grant_beat_i,
    input  logic [BEAT_W-1:0]       grant_data_i,
    input  logic                    l2_hit_i,
    output logic                    acquire_valid_o,
    output logic [BLOCK_ADDR_W-1:0] acquire_addr_o,
    output logic                    fill_done_o,
    output logic [LINE_W-1:0]       fill_line_o,

    // Walker to data cache
    input  logic                    ptw_valid_i,
    input  logic [PADDR_W-1:0]      ptw_addr_i,
    input  logic [DWORD_W-1:0]      ptw_data_i,
    input  logic [PTW_CMD_W-1:0]    ptw_cmd_i,
    input  logic [DC_SIZE_W-1:0]    ptw_size_i,
    output logic                    ptw_ready_o,
    input  logic                    dc_ready_i,
    output logic                    dc_valid_o,
    output logic [PADDR_W-1:0]      dc_addr_o,
    output logic [DWORD_W-1:0]      dc_wdata_o,
    output dc_op_e                  dc_op_o,
    output logic [DC_BE_W-1:0]      dc_be_o,
    output logic [DC_SIZE_W-1:0]    dc_size_o,
    output logic [PADDR_W-1:0]      last_addr_o,

    // Counter access
    input  logic [HPM_ADDR_W-1:0]   hpm_addr_i,
    input  logic                    hpm_we_i,
    input  logic [HPM_CNT_W-1:0]    hpm_wdata_i,
    output logic [HPM_CNT_W-1:0]    hpm_rdata_o
);

    logic [HPM_COUNTERS-1:0] hpm_events;

    // ------------------------------------------------------------
    // Adapters
    // ------------------------------------------------------------
    refill_bridge refill_bridge_i (
        .CLK             (CLK),
        .RST             (RST),
        .fill_req_i      (fill_req_i),
        .fill_addr_i     (fill_addr_i),
        .grant_valid_i   (grant_valid_i),
        .grant_beat_i    (grant_beat_i),
        .grant_data_i    (grant_data_i),
        .l2_hit_i        (l2_hit_i),
        .acquire_valid_o (acquire_valid_o),
        .acquire_addr_o  (acquire_addr_o),
        .fill_done_o     (fill_done_o),
        .fill_line_o     (fill_line_o),
        .ev_refill_o     (hpm_events[EV_REFILL]),
        .ev_l2_hit_o     (hpm_events[EV_L2_HIT])
    );

    ptw_dcache_port ptw_dcache_port_i (
        .CLK         (CLK),
        .RST         (RST),
        .ptw_valid_i (ptw_valid_i),
        .ptw_addr_i  (ptw_addr_i),
        .ptw_data_i  (ptw_data_i),
        .ptw_cmd_i   (ptw_cmd_i),
        .ptw_size_i  (ptw_size_i),
        .ptw_ready_o (ptw_ready_o),
        .dc_ready_i  (dc_ready_i),
        .dc_valid_o  (dc_valid_o),
        .dc_addr_o   (dc_addr_o),
        .dc_wdata_o  (dc_wdata_o),
        .dc_op_o     (dc_op_o),
        .dc_be_o     (dc_be_o),
        .dc_size_o   (dc_size_o),
        .last_addr_o (last_addr_o),
        .ev_load_o   (hpm_events[EV_PTW_LOAD]),
        .ev_amo_o    (hpm_events[EV_PTW_AMO])
    );

    // Event counters
    hpm_counters hpm_counters_i (
        .CLK      (CLK),
        .RST      (RST),
        .events_i (hpm_events),
        .addr_i   (hpm_addr_i),
        .we_i     (hpm_we_i),
        .wdata_i  (hpm_wdata_i),
        .rdata_o  (hpm_rdata_o)
    );

endmodule

/* tb/tb_mem_glue.sv */
`timescale 1ns/1ps

module tb_mem_glue
    import mem_bus_pkg::*, hpm_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int PULSE_WAIT = 8;     // Cycles allowed for any awaited pulse

    // Summed worst case of reset, refills, walker transfers and counter reads
    localparam int WORST_CYCLES = 9 + 3 * (2 * PULSE_WAIT + 8) + 4 * (PULSE_WAIT + 6) + 12;

    logic                    CLK;
    logic                    RST;
    logic                    fill_req_i;
    logic [BLOCK_ADDR_W-1:0] fill_addr_i;
    logic                    grant_valid_i;
    logic [BEAT_IDX_W-1:0]   grant_beat_i;
    logic [BEAT_W-1:0]       grant_data_i;
    logic                    l2_hit_i;
    logic                    acquire_valid_o;
    logic [BLOCK_ADDR_W-1:0] acquire_addr_o;
    logic                    fill_done_o;
    logic [LINE_W-1:0]       fill_line_o;
    logic                    ptw_valid_i;
    logic [PADDR_W-1:0]      ptw_addr_i;
    logic [DWORD_W-1:0]      ptw_data_i;
    logic [PTW_CMD_W-1:0]    ptw_cmd_i;
    logic [DC_SIZE_W-1:0]    ptw_size_i;
    logic                    ptw_ready_o;
    logic                    dc_ready_i;
    logic                    dc_valid_o;
    logic [PADDR_W-1:0]      dc_addr_o;
    logic [DWORD_W-1:0]      dc_wdata_o;
    dc_op_e                  dc_op_o;
    logic [DC_BE_W-1:0]      dc_be_o;
    logic [DC_SIZE_W-1:0]    dc_size_o;
    logic [PADDR_W-1:0]      last_addr_o;
    logic [HPM_ADDR_W-1:0]   hpm_addr_i;
    logic                    hpm_we_i;
    logic [HPM_CNT_W-1:0]    hpm_wdata_i;
    logic [HPM_CNT_W-1:0]    hpm_rdata_o;

    int errors     = 0;
    int acq_count  = 0;
    int done_count = 0;
    int n_refill   = 0;
    int n_hit      = 0;
    int n_load     = 0;
    int n_amo      = 0;

    mem_glue_top mem_glue_top_i (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Pulse counts sampled away from the rising edge
    always @(negedge CLK) begin
        if (acquire_valid_o) acq_count++;
        if (fill_done_o) done_count++;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic step();
        @(posedge CLK);
        #2;
    endtask

    task automatic compare_value(input string name, input logic [LINE_W-1:0] got,
                                 input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic start_fill(input logic [BLOCK_ADDR_W-1:0] addr);
        bit seen;
        fill_req_i  = 1'b1;
        fill_addr_i = addr;
        step();
        fill_req_i = 1'b0;
        seen       = 1'b0;
        for (int i = 0; i < PULSE_WAIT && !seen; i++) begin
            if (acquire_valid_o) begin
                seen = 1'b1;
            end else begin
                step();
            end
        end
        if (!seen) begin
            $display("ERROR: no acquire pulse followed the fill request");
            errors++;
        end else begin
            compare_value("acquire_addr_o", acquire_addr_o, addr);
        end
    endtask

    // Beats go out as 2, 0, 1, 3 so the last index closes the refill
    task automatic send_line(input bit hit);
        logic [BEAT_W-1:0]     beats [BEATS];
        logic [BEAT_IDX_W-1:0] order [BEATS];
        bit                    seen;
        int                    done0;
        order = '{2'd2, 2'd0, 2'd1, 2'd3};
        for (int k = 0; k < BEATS; k++) begin
            beats[k] = {$urandom, $urandom, $urandom, $urandom};
        end
        done0 = done_count;
        for (int n = 0; n < BEATS; n++) begin
            grant_valid_i = 1'b1;
            grant_beat_i  = order[n];
            grant_data_i  = beats[order[n]];
            // Only the level on the last beat may count
            l2_hit_i      = (order[n] == 2'd3) ? hit : ~hit;
            step();
        end
        grant_valid_i = 1'b0;
        l2_hit_i      = 1'b0;
        seen          = 1'b0;
        for (int i = 0; i < PULSE_WAIT && !seen; i++) begin
            if (fill_done_o) begin
                seen = 1'b1;
            end else begin
                step();
            end
        end
        if (!seen) begin
            $display("ERROR: no done pulse after the last grant beat");
            errors++;
        end else begin
            compare_value("fill_line_o", fill_line_o, {beats[3], beats[2], beats[1], beats[0]});
        end
        step();
        compare_value("fill_done_o", fill_done_o, 1'b0);
        compare_value("done pulse count", done_count - done0, 1);
        n_refill++;
        if (hit) n_hit++;
    endtask

    task automatic issue_ptw(input logic [PTW_CMD_W-1:0] cmd, output logic [PADDR_W-1:0] addr,
                             output logic [DWORD_W-1:0] data, output logic [DC_SIZE_W-1:0] size);
        logic [63:0] r;
        bit          ready;
        r    = {$urandom, $urandom};
        addr = r[PADDR_W-1:0];
        data = {$urandom, $urandom};
        r    = {32'd0, $urandom};
        size = r[DC_SIZE_W-1:0];
        ptw_valid_i = 1'b1;
        ptw_addr_i  = addr;
        ptw_data_i  = data;
        ptw_cmd_i   = cmd;
        ptw_size_i  = size;
        ready       = 1'b0;
        for (int i = 0; i < PULSE_WAIT && !ready; i++) begin
            #1;
            if (ptw_ready_o) begin
                ready = 1'b1;
            end else begin
                step();
            end
        end
        if (!ready) begin
            $display("ERROR: walker request was never accepted");
            errors++;
        end
        step();                                      // Accepting edge
        ptw_valid_i = 1'b0;
    endtask

    task automatic check_dc_req(input logic [PTW_CMD_W-1:0] cmd, input logic [PADDR_W-1:0] addr,
                                input logic [DWORD_W-1:0] data, input logic [DC_SIZE_W-1:0] size);
        dc_op_e             exp_op;
        logic [DC_BE_W-1:0] exp_be;
        if (cmd == 5'b01010) begin
            exp_op = DC_OP_AMO_OR;
            exp_be = 8'hff;
        end else begin
            exp_op = DC_OP_LOAD;
            exp_be = 8'h00;
        end
        compare_value("dc_valid_o", dc_valid_o, 1'b1);
        compare_value("dc_op_o", dc_op_o, exp_op);
        compare_value("dc_be_o", dc_be_o, exp_be);
        compare_value("dc_addr_o", dc_addr_o, addr);
        compare_value("dc_wdata_o", dc_wdata_o, data);
        compare_value("dc_size_o", dc_size_o, size);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_refill();
        logic [63:0] r;
        int          acq0;
        r    = {$urandom, $urandom};
        acq0 = acq_count;
        start_fill(r[BLOCK_ADDR_W-1:0]);
        send_line(1'b0);
        compare_value("acquire pulse count", acq_count - acq0, 1);
    endtask

    task automatic test_busy_ignore();
        logic [63:0] r;
        int          acq0;
        r    = {$urandom, $urandom};
        acq0 = acq_count;
        start_fill(r[BLOCK_ADDR_W-1:0]);
        fill_req_i  = 1'b1;                          // Second strobe while busy
        fill_addr_i = ~r[BLOCK_ADDR_W-1:0];
        step();
        fill_req_i = 1'b0;
        step();
        step();
        compare_value("acquire pulse count while busy", acq_count - acq0, 1);
        send_line(1'b1);
        r = {$urandom, $urandom};
        start_fill(r[BLOCK_ADDR_W-1:0]);
        send_line(1'b0);
        compare_value("acquire pulse count", acq_count - acq0, 2);
    endtask

    task automatic test_walker_decode();
        logic [63:0]          r;
        logic [PTW_CMD_W-1:0] cmd;
        logic [PADDR_W-1:0]   a;
        logic [DWORD_W-1:0]   d;
        logic [DC_SIZE_W-1:0] s;
        dc_ready_i = 1'b1;
        issue_ptw(5'b01010, a, d, s);
        check_dc_req(5'b01010, a, d, s);
        step();
        compare_value("dc_valid_o", dc_valid_o, 1'b0);
        compare_value("last_addr_o", last_addr_o, a);
        n_amo++;
        r   = {32'd0, $urandom};
        cmd = r[PTW_CMD_W-1:0];
        if (cmd == 5'b01010) cmd = 5'b01011;
        issue_ptw(cmd, a, d, s);
        check_dc_req(cmd, a, d, s);
        step();
        compare_value("dc_valid_o", dc_valid_o, 1'b0);
        compare_value("last_addr_o", last_addr_o, a);
        n_load++;
    endtask

    task automatic test_back_pressure();
        logic [PADDR_W-1:0]   a;
        logic [DWORD_W-1:0]   d;
        logic [DC_SIZE_W-1:0] s;
        logic [PADDR_W-1:0]   a2;
        logic [DWORD_W-1:0]   d2;
        logic [DC_SIZE_W-1:0] s2;
        dc_ready_i = 1'b0;
        issue_ptw(5'b00011, a, d, s);
        a2 = ~a;
        d2 = ~d;
        s2 = ~s;
        // Next walker request waits behind the stalled one
        ptw_valid_i = 1'b1;
        ptw_addr_i  = a2;
        ptw_data_i  = d2;
        ptw_cmd_i   = 5'b01010;
        ptw_size_i  = s2;
        repeat (4) begin
            check_dc_req(5'b00011, a, d, s);         // Fields must hold
            compare_value("ptw_ready_o", ptw_ready_o, 1'b0);
            step();
        end
        dc_ready_i = 1'b1;
        step();                                      // Stalled request drains, next one enters
        ptw_valid_i = 1'b0;
        compare_value("last_addr_o", last_addr_o, a);
        check_dc_req(5'b01010, a2, d2, s2);
        n_load++;
        step();
        compare_value("dc_valid_o", dc_valid_o, 1'b0);
        compare_value("last_addr_o", last_addr_o, a2);
        n_amo++;
    endtask

    task automatic test_counters();
        int          exp [HPM_COUNTERS];
        logic [63:0] w;
        exp[EV_REFILL]   = n_refill;
        exp[EV_L2_HIT]   = n_hit;
        exp[EV_PTW_LOAD] = n_load;
        exp[EV_PTW_AMO]  = n_amo;
        step();
        for (int k = 0; k < HPM_COUNTERS; k++) begin
            hpm_addr_i = 12'hB03 + 12'(k);
            #1;
            compare_value("hpm_rdata_o", hpm_rdata_o, exp[k]);
            step();
        end
        w           = {$urandom, $urandom};
        hpm_addr_i  = 12'hB05;
        hpm_wdata_i = w;
        hpm_we_i    = 1'b1;
        step();
        hpm_we_i = 1'b0;
        #1;
        compare_value("hpm_rdata_o", hpm_rdata_o, w);
        hpm_addr_i = 12'hB07;                        // Just past the last counter
        #1;
        compare_value("hpm_rdata_o", hpm_rdata_o, 0);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        int unsigned seed_val;
        seed_val      = $urandom(32'h1630);
        CLK           = 1'b0;
        RST           = 1'b0;
        fill_req_i    = 1'b0;
        fill_addr_i   = '0;
        grant_valid_i = 1'b0;
        grant_beat_i  = '0;
        grant_data_i  = '0;
        l2_hit_i      = 1'b0;
        ptw_valid_i   = 1'b0;
        ptw_addr_i    = '0;
        ptw_data_i    = '0;
        ptw_cmd_i     = '0;
        ptw_size_i    = '0;
        dc_ready_i    = 1'b1;
        hpm_addr_i    = '0;
        hpm_we_i      = 1'b0;
        hpm_wdata_i   = '0;
        repeat (8) @(posedge CLK);
        #2;
        RST = 1'b1;
        step();
        test_refill();
        test_busy_ignore();
        test_walker_decode();
        test_back_pressure();
        test_counters();
        $display("Summary: %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(2 * WORST_CYCLES * CLK_PERIOD);
        $display("ERROR: simulation timed out before the tests finished");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* mem_glue.f */
src/mem_bus_pkg.sv
src/hpm_pkg.sv
src/refill_bridge.sv
src/ptw_dcache_port.sv
src/hpm_counters.sv
src/mem_glue_top.sv
tb/tb_mem_glue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the mem_glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mem_glue -f mem_glue.f -o tb_mem_glue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0
